// File: Bender.yml
package:
  name: wb_reg_subsystem

sources:
  # Package first, then leaf blocks, then the top level
  - files:
      - source/wbRegPkg.sv
      - source/wbAckDecode.sv
      - source/wbDeviceIdRegs.sv
      - source/wbScratchBank.sv
      - source/wbReadMux.sv
      - source/wbRegSubsystem.sv

  # Testbench with its model header
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/wbRegSubsystem_tb.sv

// File: dv/wbRegModel.svh
/*
 * Reference model of the register map
 * Mirrors the writable registers and predicts read data
 */
`ifndef WB_REG_MODEL_SVH
`define WB_REG_MODEL_SVH

logic [DATA_WIDTH-1:0] modelIdScratch;                     // Slot 0 scratch copy
logic [DATA_WIDTH-1:0] modelBank [NUM_BANKS][BANK_REGS];   // One row per bank

// Back to the reset state
function automatic void modelReset();
    modelIdScratch = ID_SCRATCH_RESET;
    for (int b = 0; b < NUM_BANKS; b++)
    begin
        for (int r = 0; r < BANK_REGS; r++)
        begin
            modelBank[b][r] = BANK_RESET;
        end
    end
endfunction

// Replace only the strobed bytes
function automatic logic [DATA_WIDTH-1:0] mergeBytes(input logic [DATA_WIDTH-1:0] oldVal,
                                                     input logic [BYTE_COUNT-1:0] stb,
                                                     input logic [DATA_WIDTH-1:0] newVal);
    logic [DATA_WIDTH-1:0] result;
    result = oldVal;
    for (int i = 0; i < BYTE_COUNT; i++)
    begin
        if (stb[i])
        begin
            result[i*BYTE_WIDTH +: BYTE_WIDTH] = newVal[i*BYTE_WIDTH +: BYTE_WIDTH];
        end
    end
    return result;
endfunction

function automatic void modelWrite(input logic [ADDR_WIDTH-1:0] adr,
                                   input logic [BYTE_COUNT-1:0] stb,
                                   input logic [DATA_WIDTH-1:0] data);
    int slot;
    int word;
    slot = adr[ADDR_WIDTH-1 -: SLOT_WIDTH];
    word = adr[WORD_WIDTH-1:0];
    if (slot == ID_SLOT && word == SCRATCH_WORD)
    begin
        modelIdScratch = mergeBytes(modelIdScratch, stb, data);
    end
    else if (slot >= FIRST_BANK_SLOT && slot < FIRST_BANK_SLOT + NUM_BANKS && word < BANK_REGS)
    begin
        modelBank[slot-FIRST_BANK_SLOT][word] =
            mergeBytes(modelBank[slot-FIRST_BANK_SLOT][word], stb, data);
    end
    // ID, revision and unmapped words ignore writes
endfunction

function automatic logic [DATA_WIDTH-1:0] modelRead(input logic [ADDR_WIDTH-1:0] adr);
    int slot;
    int word;
    slot = adr[ADDR_WIDTH-1 -: SLOT_WIDTH];
    word = adr[WORD_WIDTH-1:0];
    if (slot == ID_SLOT)
    begin
        if (word == ID_WORD)
            return DATA_WIDTH'(DEVICE_ID);   // Zero-extended
        if (word == REV_WORD)
            return DATA_WIDTH'(REV_LEVEL);
        if (word == SCRATCH_WORD)
            return modelIdScratch;
    end
    else if (slot < FIRST_BANK_SLOT + NUM_BANKS && word < BANK_REGS)
    begin
        return modelBank[slot-FIRST_BANK_SLOT][word];
    end
    return DEFAULT_READ;          // Unmapped word or slots 5 to 7
endfunction

`endif

// File: dv/wbRegSubsystem_tb.sv
/*
 * Testbench for the Wishbone register subsystem
 * Random bus transfers from a fixed seed, checked against a register model
 */
`timescale 1ns/1ps

module wbRegSubsystem_tb;

    import wbRegPkg::*;

    `include "wbRegModel.svh"

    // ------------------------------------------------------------
    // Run parameters
    // ------------------------------------------------------------
    localparam int SEED           = 94538;
    localparam int NUM_RANDOM     = 250;     // Random transfers
    localparam int RESET_CYCLES   = 5;
    // Reset plus about 400 transfers of at most five cycles, with margin
    localparam int TIMEOUT_CYCLES = 2500;

    logic                       WBs_CLK_i;
    logic                       WBs_RST_i;
    logic [ADDR_WIDTH-1:0]      wbsAdr;
    logic                       wbsCyc;
    logic                       wbsStb;
    logic                       wbsWe;
    logic [BYTE_COUNT-1:0]      wbsByteStb;
    logic [DATA_WIDTH-1:0]      wbsDatIn;
    logic [DATA_WIDTH-1:0]      wbsDatOut;
    logic                       wbsAck;
    logic [DEVICE_ID_WIDTH-1:0] deviceId;

    int errorCount = 0;
    int checkCount = 0;
    int cycleCount = 0;

    wbRegSubsystem UUT (
        .WBs_CLK_i    (WBs_CLK_i),
        .WBs_RST_i    (WBs_RST_i),
        .wbsAdr_i     (wbsAdr),
        .wbsCyc_i     (wbsCyc),
        .wbsStb_i     (wbsStb),
        .wbsWe_i      (wbsWe),
        .wbsByteStb_i (wbsByteStb),
        .wbsDat_i     (wbsDatIn),
        .wbsDat_o     (wbsDatOut),
        .wbsAck_o     (wbsAck),
        .deviceId_o   (deviceId)
    );

    always #10 WBs_CLK_i = ~WBs_CLK_i;       // 20 ns period

    // Hang guard
    always @(posedge WBs_CLK_i)
    begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, the bus never finished", cycleCount);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    task automatic checkValue(input string testName, input logic [DATA_WIDTH-1:0] expected,
                              input logic [DATA_WIDTH-1:0] actual);
        checkCount++;
        assert (actual === expected)
        else
        begin
            errorCount++;
            $display("CHECK FAILED %s expected %08h actual %08h", testName, expected, actual);
        end
    endtask

    // One transfer, entered and left on a falling edge
    task automatic busTransfer(input string testName, input logic [ADDR_WIDTH-1:0] adr,
                               input logic we, input logic [BYTE_COUNT-1:0] stb,
                               input logic [DATA_WIDTH-1:0] data);
        int waitCycles;
        int idleCycles;
        logic [DATA_WIDTH-1:0] expected;
        expected   = modelRead(adr);
        wbsAdr     = adr;
        wbsWe      = we;
        wbsByteStb = stb;
        wbsDatIn   = data;
        wbsCyc     = 1'b1;
        wbsStb     = 1'b1;
        @(negedge WBs_CLK_i);
        waitCycles = 1;
        while (!wbsAck)
        begin
            @(negedge WBs_CLK_i);
            waitCycles++;
        end
        checkValue({testName, " ack latency"}, 1, waitCycles);
        if (we)
            modelWrite(adr, stb, data);            // Lands on the ack edge
        else
            checkValue(testName, expected, wbsDatOut);
        checkValue({testName, " device id"}, DATA_WIDTH'(DEVICE_ID), DATA_WIDTH'(deviceId));
        wbsCyc = 1'b0;
        wbsStb = 1'b0;
        wbsWe  = 1'b0;
        @(negedge WBs_CLK_i);
        checkValue({testName, " ack width"}, 0, DATA_WIDTH'(wbsAck));   // One cycle only
        idleCycles = $urandom_range(0, 2);
        repeat (idleCycles) @(negedge WBs_CLK_i);
    endtask

    // Mapped words only, ID block or a bank register
    function automatic logic [ADDR_WIDTH-1:0] pickMappedAddress();
        int r;
        int bank;
        r = $urandom_range(0, 3 + NUM_BANKS * BANK_REGS - 1);
        if (r < 3)
            return {SLOT_WIDTH'(ID_SLOT), WORD_WIDTH'(r)};
        bank = (r - 3) / BANK_REGS;
        return {SLOT_WIDTH'(FIRST_BANK_SLOT + bank), WORD_WIDTH'((r - 3) % BANK_REGS)};
    endfunction

    // Strobe held through the ack, acks must alternate
    task automatic holdStrobe();
        logic [DATA_WIDTH-1:0] expected;
        expected = modelRead({SLOT_WIDTH'(ID_SLOT), ID_WORD});
        wbsAdr   = {SLOT_WIDTH'(ID_SLOT), ID_WORD};
        wbsWe    = 1'b0;
        wbsCyc   = 1'b1;
        wbsStb   = 1'b1;
        for (int k = 1; k <= 6; k++)
        begin
            @(negedge WBs_CLK_i);
            checkValue("held strobe ack", DATA_WIDTH'(k % 2), DATA_WIDTH'(wbsAck));
            if (wbsAck)
                checkValue("held strobe read", expected, wbsDatOut);
        end
        wbsCyc = 1'b0;
        wbsStb = 1'b0;
        @(negedge WBs_CLK_i);
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial
    begin
        logic [ADDR_WIDTH-1:0] adr;
        logic                  we;
        WBs_CLK_i  = 1'b0;
        WBs_RST_i  = 1'b1;
        wbsAdr     = '0;
        wbsCyc     = 1'b1;            // Read request pending through reset
        wbsStb     = 1'b1;
        wbsWe      = 1'b0;
        wbsByteStb = '0;
        wbsDatIn   = '0;
        void'($urandom(SEED));
        modelReset();

        // Ack stays low through reset despite the request
        repeat (RESET_CYCLES)
        begin
            @(negedge WBs_CLK_i);
            checkValue("reset ack", 0, DATA_WIDTH'(wbsAck));
        end
        WBs_RST_i = 1'b0;
        wbsCyc    = 1'b0;
        wbsStb    = 1'b0;
        @(negedge WBs_CLK_i);

        // Reset values of slots 0 to 4
        for (int s = 0; s < FIRST_BANK_SLOT + NUM_BANKS; s++)
        begin
            for (int w = 0; w < BANK_REGS; w++)
            begin
                busTransfer("reset read", {SLOT_WIDTH'(s), WORD_WIDTH'(w)}, 1'b0, '0, '0);
            end
        end

        // ID and revision are read-only
        busTransfer("id write", {SLOT_WIDTH'(ID_SLOT), ID_WORD}, 1'b1, '1, '1);
        busTransfer("id read", {SLOT_WIDTH'(ID_SLOT), ID_WORD}, 1'b0, '0, '0);
        busTransfer("rev write", {SLOT_WIDTH'(ID_SLOT), REV_WORD}, 1'b1, '1, '1);
        busTransfer("rev read", {SLOT_WIDTH'(ID_SLOT), REV_WORD}, 1'b0, '0, '0);

        holdStrobe();

        // Mostly mapped words, some anywhere in the space
        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            if ($urandom_range(0, 9) < 8)
                adr = pickMappedAddress();
            else
                adr = ADDR_WIDTH'($urandom_range(0, (1 << ADDR_WIDTH) - 1));
            we = $urandom_range(0, 1);
            if (we)
                busTransfer("random write", adr, 1'b1, BYTE_COUNT'($urandom), $urandom);
            else
                busTransfer("random read", adr, 1'b0, BYTE_COUNT'($urandom), $urandom);
        end

        // Full sweep, every word against the model
        for (int a = 0; a < (1 << ADDR_WIDTH); a++)
        begin
            busTransfer("final sweep", ADDR_WIDTH'(a), 1'b0, '0, '0);
        end

        $display("Checks %0d, errors %0d, cycles %0d", checkCount, errorCount, cycleCount);
        if (errorCount == 0)
        begin
            $display("Simulation PASSED");
        end
        else
        begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: source/wbAckDecode.sv
/*
 * Wishbone slot decoder and acknowledge generator
 * One-cycle acknowledge, one-hot read select, per-slot write enables
 */
`timescale 1ns/1ps

module wbAckDecode (
    input  logic                            WBs_CLK_i,
    input  logic                            WBs_RST_i,
    input  logic                            wbsCyc_i,      // Cycle, i.e. chip select
    input  logic                            wbsStb_i,      // Transfer strobe
    input  logic                            wbsWe_i,       // High for a write
    input  logic [wbRegPkg::SLOT_WIDTH-1:0] wbsSlot_i,     // Upper address bits
    output logic                            wbsAck_o,
    output logic [wbRegPkg::NUM_SLOTS-1:0]  slotWrEn_o,    // One bit per slot
    output logic [wbRegPkg::NUM_SLOTS-1:0]  slotRdSel_o    // One-hot by slot
);

    import wbRegPkg::*;

    // ------------------------------------------------------------
    // Request qualification
    // ------------------------------------------------------------
    logic reqActive;    // Host is asking for a transfer
    logic ackNext;      // Acknowledge for the next clock

    assign reqActive = wbsCyc_i & wbsStb_i;

    // Low ack gate keeps a held strobe from being acked twice in a row
    assign ackNext = reqActive & ~wbsAck_o;

    // ------------------------------------------------------------
    // Acknowledge flop
    // ------------------------------------------------------------
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            wbsAck_o <= 1'b0;
        end
        else
        begin
            wbsAck_o <= ackNext;        // High for exactly one cycle
        end
    end

    // ------------------------------------------------------------
    // Slot decode
    // ------------------------------------------------------------
    // Read select follows the address alone, data is combinational
    always_comb
    begin
        for (int s = 0; s < NUM_SLOTS; s++)
        begin
            slotRdSel_o[s] = (wbsSlot_i == SLOT_WIDTH'(s));
        end
    end

    // Write enable only during the first cycle of a write request.
    // Unmapped slots still get a bit here, nothing listens to it.
    assign slotWrEn_o = slotRdSel_o & {NUM_SLOTS{ackNext & wbsWe_i}};

endmodule

// File: source/wbDeviceIdRegs.sv
/*
 * Identification block in slot 0
 * Read-only device ID and revision, byte-writable scratch register
 */
`timescale 1ns/1ps

module wbDeviceIdRegs (
    input  logic                                 WBs_CLK_i,
    input  logic                                 WBs_RST_i,
    input  logic                                 wrEn_i,       // Slot 0 write enable
    input  logic [wbRegPkg::WORD_WIDTH-1:0]      wordAdr_i,    // Word within the slot
    input  logic [wbRegPkg::BYTE_COUNT-1:0]      byteStb_i,
    input  logic [wbRegPkg::DATA_WIDTH-1:0]      wrData_i,
    output logic [wbRegPkg::DATA_WIDTH-1:0]      rdData_o,
    output logic                                 rdHit_o,      // Word is mapped here
    output logic [wbRegPkg::DEVICE_ID_WIDTH-1:0] deviceId_o
);

    import wbRegPkg::*;

    logic [DATA_WIDTH-1:0] scratchReg;
    logic                  scratchWrEn;

    // ------------------------------------------------------------
    // Scratch register
    // ------------------------------------------------------------
    assign scratchWrEn = wrEn_i & (wordAdr_i == SCRATCH_WORD);

    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            scratchReg <= ID_SCRATCH_RESET;
        end
        else if (scratchWrEn)
        begin
            // Merge only the strobed bytes
            for (int b = 0; b < BYTE_COUNT; b++)
            begin
                if (byteStb_i[b])
                begin
                    scratchReg[b*BYTE_WIDTH +: BYTE_WIDTH] <= wrData_i[b*BYTE_WIDTH +: BYTE_WIDTH];
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Read back
    // ------------------------------------------------------------
    // ID and revision are constants, writes to them fall through
    always_comb
    begin
        rdHit_o  = 1'b1;
        rdData_o = '0;
        case (wordAdr_i)
            ID_WORD:      rdData_o = {{(DATA_WIDTH-DEVICE_ID_WIDTH){1'b0}}, DEVICE_ID};
            REV_WORD:     rdData_o = {{(DATA_WIDTH-REV_WIDTH){1'b0}}, REV_LEVEL};
            SCRATCH_WORD: rdData_o = scratchReg;
            default:      rdHit_o  = 1'b0;     // Read mux supplies the miss pattern
        endcase
    end

    // Device ID also leaves the block as a static level
    assign deviceId_o = DEVICE_ID;

endmodule

// File: source/wbReadMux.sv
/*
 * Read data multiplexer
 * Picks the selected slot's data on a hit, else the miss pattern
 */
`timescale 1ns/1ps

module wbReadMux (
    input  logic [wbRegPkg::NUM_SLOTS-1:0]  slotRdSel_i,   // One-hot by slot
    input  logic [wbRegPkg::DATA_WIDTH-1:0] idRdData_i,
    input  logic                            idRdHit_i,
    input  logic [wbRegPkg::DATA_WIDTH-1:0] bankRdData_i [wbRegPkg::NUM_BANKS],
    input  logic [wbRegPkg::NUM_BANKS-1:0]  bankRdHit_i,
    output logic [wbRegPkg::DATA_WIDTH-1:0] rdData_o
);

    import wbRegPkg::*;

    // ------------------------------------------------------------
    // Source selection
    // ------------------------------------------------------------
    // Select is one-hot so at most one source can win.
    // Slots above the last bank have no source and keep the default.
    always_comb
    begin
        rdData_o = DEFAULT_READ;

        // Identification block
        if (slotRdSel_i[ID_SLOT] && idRdHit_i)
        begin
            rdData_o = idRdData_i;
        end

        // Scratch banks, one slot each
        for (int b = 0; b < NUM_BANKS; b++)
        begin
            if (slotRdSel_i[FIRST_BANK_SLOT + b] && bankRdHit_i[b])
            begin
                rdData_o = bankRdData_i[b];
            end
        end
    end

endmodule

// File: source/wbRegPkg.sv
/*
 * Wishbone register subsystem definitions
 * Address map, bus widths, register reset values and miss pattern
 */
package wbRegPkg;

    // ------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------
    localparam int ADDR_WIDTH = 7;                      // Word address, 128 words
    localparam int DATA_WIDTH = 32;
    localparam int BYTE_WIDTH = 8;
    localparam int BYTE_COUNT = DATA_WIDTH / BYTE_WIDTH;  // Byte strobes per word

    // Address split, slot on top and word below
    localparam int SLOT_WIDTH = 3;
    localparam int WORD_WIDTH = ADDR_WIDTH - SLOT_WIDTH;  // 4 bits, 16 words per slot
    localparam int NUM_SLOTS  = 1 << SLOT_WIDTH;

    // ------------------------------------------------------------
    // Slot map
    // ------------------------------------------------------------
    localparam int ID_SLOT         = 0;                 // Identification block
    localparam int FIRST_BANK_SLOT = 1;                 // Banks fill slots 1 to 4
    localparam int NUM_BANKS       = 4;
    localparam int BANK_REGS       = 4;                 // Words 0 to 3 of each bank
    localparam int BANK_IDX_WIDTH  = $clog2(BANK_REGS);

    // Word offsets inside the identification slot
    localparam logic [WORD_WIDTH-1:0] ID_WORD      = 4'd0;
    localparam logic [WORD_WIDTH-1:0] REV_WORD     = 4'd1;
    localparam logic [WORD_WIDTH-1:0] SCRATCH_WORD = 4'd2;

    // ------------------------------------------------------------
    // Fixed values and reset values
    // ------------------------------------------------------------
    localparam int DEVICE_ID_WIDTH = 20;
    localparam int REV_WIDTH       = 16;

    localparam logic [DEVICE_ID_WIDTH-1:0] DEVICE_ID = 20'h610EE;
    localparam logic [REV_WIDTH-1:0]       REV_LEVEL = 16'h0100;

    localparam logic [DATA_WIDTH-1:0] ID_SCRATCH_RESET = 32'h1234_5678;
    localparam logic [DATA_WIDTH-1:0] BANK_RESET       = 32'h0000_0000;
    localparam logic [DATA_WIDTH-1:0] DEFAULT_READ     = 32'hFABD_EFAC;  // Any unmapped word

endpackage

// File: source/wbRegSubsystem.sv
/*
 * Wishbone register subsystem top level
 * Decoder, identification block, scratch banks and read multiplexer
 */
`timescale 1ns/1ps

module wbRegSubsystem (
    input  logic                                 WBs_CLK_i,
    input  logic                                 WBs_RST_i,
    input  logic [wbRegPkg::ADDR_WIDTH-1:0]      wbsAdr_i,       // Word address
    input  logic                                 wbsCyc_i,
    input  logic                                 wbsStb_i,
    input  logic                                 wbsWe_i,
    input  logic [wbRegPkg::BYTE_COUNT-1:0]      wbsByteStb_i,
    input  logic [wbRegPkg::DATA_WIDTH-1:0]      wbsDat_i,       // Write data
    output logic [wbRegPkg::DATA_WIDTH-1:0]      wbsDat_o,       // Read data
    output logic                                 wbsAck_o,
    output logic [wbRegPkg::DEVICE_ID_WIDTH-1:0] deviceId_o
);

    import wbRegPkg::*;

    // ------------------------------------------------------------
    // Address split and internal nets
    // ------------------------------------------------------------
    logic [SLOT_WIDTH-1:0] wbsSlot;
    logic [WORD_WIDTH-1:0] wbsWord;

    logic [NUM_SLOTS-1:0]  slotWrEn;
    logic [NUM_SLOTS-1:0]  slotRdSel;

    logic [DATA_WIDTH-1:0] idRdData;
    logic                  idRdHit;
    logic [DATA_WIDTH-1:0] bankRdData [NUM_BANKS];
    logic [NUM_BANKS-1:0]  bankRdHit;

    assign wbsSlot = wbsAdr_i[ADDR_WIDTH-1 -: SLOT_WIDTH];   // Upper bits
    assign wbsWord = wbsAdr_i[WORD_WIDTH-1:0];               // Lower bits

    // Ack, selects and write enables
    wbAckDecode uAckDecode (
        .WBs_CLK_i   (WBs_CLK_i),
        .WBs_RST_i   (WBs_RST_i),
        .wbsCyc_i    (wbsCyc_i),
        .wbsStb_i    (wbsStb_i),
        .wbsWe_i     (wbsWe_i),
        .wbsSlot_i   (wbsSlot),
        .wbsAck_o    (wbsAck_o),
        .slotWrEn_o  (slotWrEn),
        .slotRdSel_o (slotRdSel)
    );

    // ------------------------------------------------------------
    // Register blocks
    // ------------------------------------------------------------
    wbDeviceIdRegs uDeviceIdRegs (
        .WBs_CLK_i  (WBs_CLK_i),
        .WBs_RST_i  (WBs_RST_i),
        .wrEn_i     (slotWrEn[ID_SLOT]),
        .wordAdr_i  (wbsWord),
        .byteStb_i  (wbsByteStb_i),
        .wrData_i   (wbsDat_i),
        .rdData_o   (idRdData),
        .rdHit_o    (idRdHit),
        .deviceId_o (deviceId_o)
    );

    // One bank per slot, starting at FIRST_BANK_SLOT
    for (genvar b = 0; b < NUM_BANKS; b++)
    begin : gBank
        wbScratchBank uScratchBank (
            .WBs_CLK_i (WBs_CLK_i),
            .WBs_RST_i (WBs_RST_i),
            .wrEn_i    (slotWrEn[FIRST_BANK_SLOT + b]),
            .wordAdr_i (wbsWord),
            .byteStb_i (wbsByteStb_i),
            .wrData_i  (wbsDat_i),
            .rdData_o  (bankRdData[b]),
            .rdHit_o   (bankRdHit[b])
        );
    end

    // Read data back to the host
    wbReadMux uReadMux (
        .slotRdSel_i  (slotRdSel),
        .idRdData_i   (idRdData),
        .idRdHit_i    (idRdHit),
        .bankRdData_i (bankRdData),
        .bankRdHit_i  (bankRdHit),
        .rdData_o     (wbsDat_o)
    );

endmodule

// File: source/wbScratchBank.sv
/*
 * Scratch bank of BANK_REGS byte-writable registers
 * Occupies the low words of one slot
 */
`timescale 1ns/1ps

module wbScratchBank (
    input  logic                            WBs_CLK_i,
    input  logic                            WBs_RST_i,
    input  logic                            wrEn_i,       // Own slot write enable
    input  logic [wbRegPkg::WORD_WIDTH-1:0] wordAdr_i,
    input  logic [wbRegPkg::BYTE_COUNT-1:0] byteStb_i,
    input  logic [wbRegPkg::DATA_WIDTH-1:0] wrData_i,
    output logic [wbRegPkg::DATA_WIDTH-1:0] rdData_o,
    output logic                            rdHit_o
);

    import wbRegPkg::*;

    logic [DATA_WIDTH-1:0]     bankRegs [BANK_REGS];
    logic                      wordInRange;   // Word maps to a register
    logic [BANK_IDX_WIDTH-1:0] regIdx;

    // ------------------------------------------------------------
    // Word decode
    // ------------------------------------------------------------
    assign wordInRange = (wordAdr_i < WORD_WIDTH'(BANK_REGS));
    assign regIdx      = wordAdr_i[BANK_IDX_WIDTH-1:0];   // Valid only when in range

    // ------------------------------------------------------------
    // Register array
    // ------------------------------------------------------------
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            for (int r = 0; r < BANK_REGS; r++)
            begin
                bankRegs[r] <= BANK_RESET;
            end
        end
        else if (wrEn_i && wordInRange)
        begin
            for (int b = 0; b < BYTE_COUNT; b++)
            begin
                if (byteStb_i[b])     // Untouched bytes keep their value
                begin
                    bankRegs[regIdx][b*BYTE_WIDTH +: BYTE_WIDTH] <=
                        wrData_i[b*BYTE_WIDTH +: BYTE_WIDTH];
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Read back
    // ------------------------------------------------------------
    // Data is don't-care on a miss, the hit flag gates it downstream
    assign rdData_o = bankRegs[regIdx];
    assign rdHit_o  = wordInRange;

endmodule

// File: sources.f
+incdir+dv
source/wbRegPkg.sv
source/wbAckDecode.sv
source/wbDeviceIdRegs.sv
source/wbScratchBank.sv
source/wbReadMux.sv
source/wbRegSubsystem.sv
dv/wbRegSubsystem_tb.sv
